// File: build.f
+incdir+test
rtl/chess_rep_pkg.sv
rtl/position_history.sv
rtl/query_queue.sv
rtl/rep_det.sv
rtl/rep_tracker_top.sv
test/rep_tracker_tb.sv

// File: rtl/chess_rep_pkg.sv
package chess_rep_pkg;

   // ####################
   // board encoding
   // ####################

   localparam int piece_bits   = 4;
   localparam int square_count = 64;
   localparam int board_width  = piece_bits * square_count;   // 256
   localparam int castle_width = 4;

   // ####################
   // history table
   // ####################

   localparam int repdet_width    = 6;
   localparam int rep_entry_width = castle_width + board_width;   // castle mask on top
   localparam int rep_table_size  = 1 << repdet_width;

   // highest window depth, pushes stop growing the window here
   localparam logic [repdet_width-1:0] depth_max = {repdet_width{1'b1}};

   // query path
   localparam int query_depth = 4;   // also the host's starting credits
   localparam int qptr_width  = $clog2(query_depth);

   typedef enum logic [2:0]
   {
      hist_nop        = 3'd0,
      hist_push       = 3'd1,
      hist_push_irrev = 3'd2,   // pawn move or capture
      hist_pop        = 3'd3,
      hist_clear      = 3'd4
   } hist_op_t;

   typedef enum logic [1:0]
   {
      rd_idle    = 2'd0,
      rd_wait    = 2'd1,   // ram read in flight
      rd_count   = 2'd2,
      rd_verdict = 2'd3
   } repdet_state_t;

endpackage

// File: rtl/position_history.sv
module position_history
   import chess_rep_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  hist_op_t                hist_op,
   input  logic [board_width-1:0]  hist_board,
   input  logic [castle_width-1:0] hist_castle,
   output logic                    wr_en,
   output logic [repdet_width-1:0] wr_addr,
   output logic [board_width-1:0]  wr_board,
   output logic [castle_width-1:0] wr_castle,
   output logic [repdet_width-1:0] depth
);

   logic                    push_any;
   logic [repdet_width-1:0] push_addr;
   logic [repdet_width-1:0] depth_next;

   // ####################
   // opcode decode
   // ####################

   always_comb
   begin
      push_any   = 1'b0;
      push_addr  = depth;
      depth_next = depth;
      case (hist_op)
         hist_push:
         begin
            push_any = 1'b1;
            if (depth == depth_max)
            begin
               push_addr = depth_max - 1'b1;   // window full, overwrite its last word
            end
            else
            begin
               depth_next = depth + 1'b1;
            end
         end
         hist_push_irrev:
         begin
            push_any   = 1'b1;
            push_addr  = '0;   // window restarts here
            depth_next = repdet_width'(1);
         end
         hist_pop:
         begin
            if (depth != '0)
            begin
               depth_next = depth - 1'b1;
            end
         end
         hist_clear:
            depth_next = '0;
         default:
            depth_next = depth;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_en <= 1'b0;
         depth <= '0;
      end
      else
      begin
         wr_en <= push_any;
         depth <= depth_next;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_any)
      begin
         wr_addr   <= push_addr;
         wr_board  <= hist_board;
         wr_castle <= hist_castle;
      end
   end

endmodule

// File: rtl/query_queue.sv
module query_queue
   import chess_rep_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    query_valid,
   input  logic [board_width-1:0]  query_board,
   input  logic [castle_width-1:0] query_castle,
   output logic                    q_valid,
   output logic [board_width-1:0]  q_board,
   output logic [castle_width-1:0] q_castle,
   input  logic                    q_pop,
   output logic                    credit_return
);

   logic [board_width-1:0]  board_mem  [query_depth];
   logic [castle_width-1:0] castle_mem [query_depth];
   logic [qptr_width-1:0]   head;
   logic [qptr_width-1:0]   tail;
   logic [qptr_width:0]     count;
   logic                    full;

   assign full     = count == (qptr_width + 1)'(query_depth);
   assign q_valid  = count != '0;
   assign q_board  = board_mem[head];
   assign q_castle = castle_mem[head];

   // entry storage, written at the tail
   always_ff @(posedge clk)
   begin
      if (query_valid)
      begin
         board_mem[tail]  <= query_board;
         castle_mem[tail] <= query_castle;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         head          <= '0;
         tail          <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end
      else
      begin
         credit_return <= q_pop;   // one credit back per entry taken
         if (query_valid)
            tail <= tail + 1'b1;
         if (q_pop)
            head <= head + 1'b1;
         case ({query_valid, q_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ####################
   // credit protocol
   // ####################

   // host spent a credit it did not have
   push_not_full: assert property (@(posedge clk) disable iff (reset)
      query_valid |-> !full)
      else $error("query pushed into a full queue");

   pop_not_empty: assert property (@(posedge clk) disable iff (reset)
      q_pop |-> q_valid)
      else $error("pop from an empty query queue");

endmodule

// File: rtl/rep_det.sv
module rep_det
   import chess_rep_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    q_valid,
   input  logic [board_width-1:0]  q_board,
   input  logic [castle_width-1:0] q_castle,
   output logic                    q_pop,
   input  logic                    wr_en,
   input  logic [repdet_width-1:0] wr_addr,
   input  logic [board_width-1:0]  wr_board,
   input  logic [castle_width-1:0] wr_castle,
   input  logic [repdet_width-1:0] depth,
   input  logic                    verdict_ack,
   output logic                    verdict_valid,
   output logic                    thrice_rep
);

   logic [rep_entry_width-1:0] table_mem [rep_table_size];
   logic [rep_entry_width-1:0] ram_read;
   logic [rep_entry_width-1:0] query_entry;
   logic [repdet_width-1:0]    rd_addr;
   logic [repdet_width-1:0]    last_addr;
   logic [repdet_width-1:0]    match_count;
   logic                       entry_match;
   repdet_state_t              state;

   // ####################
   // history table
   // ####################

   always_ff @(posedge clk)
   begin
      ram_read <= table_mem[rd_addr];   // one cycle read latency
      if (wr_en)
      begin
         table_mem[wr_addr] <= {wr_castle, wr_board};
      end
   end

   assign entry_match = ram_read == query_entry;   // board and castle rights compared bit for bit

   assign q_pop         = (state == rd_idle) && q_valid;
   assign verdict_valid = state == rd_verdict;
   // two earlier matches plus the current position
   assign thrice_rep    = verdict_valid && (match_count >= repdet_width'(2));

   // query sampled as it leaves the queue
   always_ff @(posedge clk)
   begin
      if (q_pop)
      begin
         query_entry <= {q_castle, q_board};
         last_addr   <= depth - 1'b1;
      end
   end

   // ####################
   // search FSM
   // ####################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= rd_idle;
         rd_addr     <= '0;
         match_count <= '0;
      end
      else
      begin
         case (state)
            rd_idle:
            begin
               rd_addr     <= '0;
               match_count <= '0;
               if (q_valid)
               begin
                  if (depth < repdet_width'(2))
                     state <= rd_verdict;   // too short to hold a repetition
                  else
                     state <= rd_wait;
               end
            end
            rd_wait:
               state <= rd_count;
            rd_count:
            begin
               rd_addr <= rd_addr + 1'b1;
               if (entry_match)
                  match_count <= match_count + 1'b1;
               if (rd_addr == last_addr)
                  state <= rd_verdict;
               else
                  state <= rd_wait;
            end
            rd_verdict:
            begin
               if (verdict_ack)
                  state <= rd_idle;   // verdict held until the host takes it
            end
            default:
               state <= rd_idle;
         endcase
      end
   end

   // table must not change under a running search
   hist_write_idle: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> state == rd_idle)
      else $error("history write while a search is in flight");

   verdict_held: assert property (@(posedge clk) disable iff (reset)
      verdict_valid && !verdict_ack |=> verdict_valid && $stable(thrice_rep))
      else $error("verdict changed before acknowledge");

endmodule

// File: rtl/rep_tracker_top.sv
module rep_tracker_top
   import chess_rep_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  hist_op_t                hist_op,
   input  logic [board_width-1:0]  hist_board,
   input  logic [castle_width-1:0] hist_castle,
   input  logic                    query_valid,
   input  logic [board_width-1:0]  query_board,
   input  logic [castle_width-1:0] query_castle,
   output logic                    credit_return,
   output logic                    verdict_valid,
   output logic                    thrice_rep,
   input  logic                    verdict_ack
);

   logic                    wr_en;
   logic [repdet_width-1:0] wr_addr;
   logic [board_width-1:0]  wr_board;
   logic [castle_width-1:0] wr_castle;
   logic [repdet_width-1:0] depth;

   logic                    q_valid;
   logic [board_width-1:0]  q_board;
   logic [castle_width-1:0] q_castle;
   logic                    q_pop;

   position_history u_history
   (
      .clk         (clk),
      .reset       (reset),
      .hist_op     (hist_op),
      .hist_board  (hist_board),
      .hist_castle (hist_castle),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_board    (wr_board),
      .wr_castle   (wr_castle),
      .depth       (depth)
   );

   query_queue u_queue
   (
      .clk           (clk),
      .reset         (reset),
      .query_valid   (query_valid),
      .query_board   (query_board),
      .query_castle  (query_castle),
      .q_valid       (q_valid),
      .q_board       (q_board),
      .q_castle      (q_castle),
      .q_pop         (q_pop),
      .credit_return (credit_return)
   );

   rep_det u_rep_det
   (
      .clk           (clk),
      .reset         (reset),
      .q_valid       (q_valid),
      .q_board       (q_board),
      .q_castle      (q_castle),
      .q_pop         (q_pop),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_board      (wr_board),
      .wr_castle     (wr_castle),
      .depth         (depth),
      .verdict_ack   (verdict_ack),
      .verdict_valid (verdict_valid),
      .thrice_rep    (thrice_rep)
   );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log && \
   verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
      --top-module rep_tracker_tb -Mdir obj_dir -o rep_tracker_sim > build.log 2>&1 && \
   ./obj_dir/rep_tracker_sim > sim.log 2>&1
grep -qx "Simulation PASSED" sim.log && echo "run passed" || { cat build.log sim.log 2>/dev/null; exit 1; }

// File: test/rep_tracker_checks.svh
// ####################
// compare tasks
// ####################

task automatic fail_run(input string why);
   $display("%s", why);
   $display("Simulation FAILED");
   $fatal(1, "stopped at first error");
endtask

task automatic check_verdict(input string name, input logic exp, input logic act);
   if (act !== exp)
      fail_run($sformatf("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act));
endtask

task automatic check_credits(input int exp, input int act);
   if (act !== exp)
      fail_run($sformatf("CHECK FAILED credits expected 0x%h got 0x%h", exp, act));
endtask

// ####################
// bounded waits
// ####################

task automatic wait_verdict();
   int n;
   n = 0;
   while (verdict_valid !== 1'b1)
   begin
      if (n == wait_timeout)
         fail_run($sformatf("no verdict arrived within %0d cycles", wait_timeout));
      next_cycle();
      n++;
   end
endtask

task automatic wait_credit();
   int n;
   n = 0;
   while (credits == 0)
   begin
      if (n == wait_timeout)
         fail_run("no query credit came back in time");
      next_cycle();
      n++;
   end
endtask

// every credit must be home by the end of the test
task automatic wait_all_credits();
   int n;
   n = 0;
   while (credits < query_depth)
   begin
      if (n == wait_timeout)
         fail_run("not all query credits came back before the end of the test");
      next_cycle();
      n++;
   end
endtask

// File: test/rep_tracker_tb.sv
module rep_tracker_tb
   import chess_rep_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int reset_cycles = 10;
   localparam int wait_timeout = 2 * rep_table_size + 40;
   localparam logic [castle_width-1:0] cr_all  = 4'b1111;
   localparam logic [castle_width-1:0] cr_lost = 4'b0111;   // one right gone

   typedef struct packed
   {
      logic                    is_query;
      hist_op_t                op;
      logic [1:0]              bidx;
      logic [castle_width-1:0] castle;
      logic                    exp_rep;
      logic                    drain;   // collect all pending verdicts after this query
   } step_t;

   localparam int step_count = 28;

   logic                    clk = 1'b0;
   logic                    reset;
   hist_op_t                hist_op;
   logic [board_width-1:0]  hist_board;
   logic [castle_width-1:0] hist_castle;
   logic                    query_valid;
   logic [board_width-1:0]  query_board;
   logic [castle_width-1:0] query_castle;
   logic                    credit_return;
   logic                    verdict_valid;
   logic                    thrice_rep;
   logic                    verdict_ack;

   logic [31:0]                lcg_state = 32'h88f9;
   logic [board_width-1:0]     board_bank [4];
   logic [rep_entry_width-1:0] model_hist [rep_table_size];
   int                         model_depth = 0;
   int                         credits = query_depth;
   logic                       pending [$];   // expected verdicts in issue order

   // ####################
   // stimulus table
   // ####################

   step_t steps [step_count] = '{
      '{1'b1, hist_nop, 2'd0, cr_all, 1'b0, 1'b0},   // four back to back into an empty window
      '{1'b1, hist_nop, 2'd1, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd2, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd3, cr_all, 1'b0, 1'b1},
      '{1'b0, hist_push, 2'd0, cr_all, 1'b0, 1'b0},
      '{1'b0, hist_push, 2'd1, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd0, cr_all, 1'b0, 1'b1},   // seen once only
      '{1'b0, hist_push, 2'd0, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd0, cr_all, 1'b1, 1'b1},
      '{1'b1, hist_nop, 2'd1, cr_all, 1'b0, 1'b1},
      '{1'b1, hist_nop, 2'd0, cr_lost, 1'b0, 1'b1},  // castle mask differs
      '{1'b0, hist_push_irrev, 2'd2, cr_all, 1'b0, 1'b0},
      '{1'b0, hist_push, 2'd0, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd0, cr_all, 1'b0, 1'b1},
      '{1'b0, hist_push, 2'd0, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd0, cr_all, 1'b1, 1'b1},
      '{1'b0, hist_pop, 2'd0, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd0, cr_all, 1'b0, 1'b1},
      '{1'b0, hist_clear, 2'd0, cr_all, 1'b0, 1'b0},
      '{1'b0, hist_push, 2'd3, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd3, cr_all, 1'b0, 1'b1},   // depth 1 skips the search
      '{1'b0, hist_push, 2'd3, cr_all, 1'b0, 1'b0},
      '{1'b0, hist_push, 2'd1, cr_all, 1'b0, 1'b0},
      '{1'b0, hist_push, 2'd3, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd3, cr_all, 1'b1, 1'b0},   // these queue up behind a held verdict
      '{1'b1, hist_nop, 2'd1, cr_all, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd3, cr_lost, 1'b0, 1'b0},
      '{1'b1, hist_nop, 2'd2, cr_all, 1'b0, 1'b1}
   };

   rep_tracker_top UUT
   (
      .clk           (clk),
      .reset         (reset),
      .hist_op       (hist_op),
      .hist_board    (hist_board),
      .hist_castle   (hist_castle),
      .query_valid   (query_valid),
      .query_board   (query_board),
      .query_castle  (query_castle),
      .credit_return (credit_return),
      .verdict_valid (verdict_valid),
      .thrice_rep    (thrice_rep),
      .verdict_ack   (verdict_ack)
   );

   always #10 clk = ~clk;

   `include "rep_tracker_checks.svh"

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // all driving happens right after the falling edge
   task automatic next_cycle();
      @(negedge clk);
      if (credit_return === 1'b1)
         credits++;
   endtask

   task automatic fill_bank();
      for (int b = 0; b < 4; b++)
         for (int w = 0; w < board_width / 32; w++)
            board_bank[b][w*32 +: 32] = lcg_next();
      for (int b = 0; b < 4; b++)
         for (int c = b + 1; c < 4; c++)
            if (board_bank[b] == board_bank[c])
               fail_run("two boards in the bank came out equal");
   endtask

   // ####################
   // history model
   // ####################

   task automatic model_apply(input hist_op_t op, input logic [rep_entry_width-1:0] entry);
      case (op)
         hist_push:
         begin
            if (model_depth == rep_table_size - 1)
               model_hist[rep_table_size - 2] = entry;   // full window keeps its size
            else
            begin
               model_hist[model_depth] = entry;
               model_depth++;
            end
         end
         hist_push_irrev:
         begin
            model_hist[0] = entry;
            model_depth = 1;
         end
         hist_pop:
            if (model_depth > 0)
               model_depth--;
         hist_clear:
            model_depth = 0;
         default:
            model_depth = model_depth;
      endcase
   endtask

   function automatic int model_count(input logic [rep_entry_width-1:0] entry);
      int n;
      n = 0;
      for (int i = 0; i < model_depth; i++)
         if (model_hist[i] === entry)
            n++;
      return n;
   endfunction

   task automatic issue_query(input logic [1:0] bidx, input logic [castle_width-1:0] castle);
      wait_credit();
      query_valid  = 1'b1;
      query_board  = board_bank[bidx];
      query_castle = castle;
      credits--;
      next_cycle();
      query_valid = 1'b0;
   endtask

   task automatic drain_verdicts();
      logic exp;
      int   idle;
      while (pending.size() > 0)
      begin
         exp = pending.pop_front();
         wait_verdict();
         check_verdict("thrice_rep", exp, thrice_rep);
         idle = int'((lcg_next() >> 16) % 32'd6);
         repeat (idle)
         begin
            next_cycle();
            check_verdict("verdict_valid", 1'b1, verdict_valid);
            check_verdict("thrice_rep", exp, thrice_rep);
         end
         verdict_ack = 1'b1;
         next_cycle();
         verdict_ack = 1'b0;
         check_verdict("verdict_valid", 1'b0, verdict_valid);   // back in idle after the ack
      end
   endtask

   task automatic apply_step(input int i);
      step_t                      s;
      logic [rep_entry_width-1:0] entry;
      s = steps[i];
      entry = {s.castle, board_bank[s.bidx]};
      if (!s.is_query)
      begin
         hist_op     = s.op;
         hist_board  = board_bank[s.bidx];
         hist_castle = s.castle;
         model_apply(s.op, entry);
         next_cycle();
         hist_op = hist_nop;
      end
      else
      begin
         if ((model_count(entry) >= 2) !== s.exp_rep)
            fail_run($sformatf("stimulus row %0d disagrees with the history model", i));
         issue_query(s.bidx, s.castle);
         pending.push_back(s.exp_rep);
         if (s.drain)
            drain_verdicts();
      end
   endtask

   initial
   begin
      reset        = 1'b1;
      hist_op      = hist_nop;
      hist_board   = '0;
      hist_castle  = '0;
      query_valid  = 1'b0;
      query_board  = '0;
      query_castle = '0;
      verdict_ack  = 1'b0;
      fill_bank();
      repeat (reset_cycles) next_cycle();
      reset = 1'b0;
      next_cycle();
      check_verdict("verdict_valid", 1'b0, verdict_valid);
      check_credits(query_depth, credits);
      for (int i = 0; i < step_count; i++)
         apply_step(i);
      wait_all_credits();
      check_credits(query_depth, credits);
      $display("Simulation PASSED");
      $finish;
   end

endmodule
